/* Bender.yml */
package:
  name: cryomodule

sources:
  - cmoc_pkg.sv
  - lb_control.sv
  - mode_drive.sv
  - resonator_mode.sv
  - field_sum.sv
  - cryomodule.sv
  - target: test
    files:
      - tb_clock.sv
      - cryomodule_assertions.sv
      - cryomodule_tb.sv

/* cmoc_pkg.sv */
package cmoc_pkg;

	// Number of cavity modes modelled in the cryomodule
	localparam int mode_count = 3;

	// Local bus word address and data
	typedef logic [16:0] lb_addr_t;
	typedef logic [31:0] lb_data_t;

	// Signed drive, also used for each mode's coupled drive
	typedef logic signed [17:0] drive_t;
	// Unsigned coupling, 16 fraction bits
	typedef logic [16:0] coupling_t;
	// Right-shift amount setting the mode bandwidth
	typedef logic [3:0] shift_t;
	typedef logic signed [17:0] mode_state_t;
	typedef logic signed [19:0] field_t;
	typedef logic [15:0] step_count_t;

	localparam int coupling_frac = 16;

	// Limits used for clamping
	localparam drive_t drive_max = {1'b0, {($bits(drive_t) - 1){1'b1}}};
	localparam drive_t drive_min = {1'b1, {($bits(drive_t) - 1){1'b0}}};
	localparam field_t field_max = {1'b0, {($bits(field_t) - 1){1'b1}}};
	localparam field_t field_min = {1'b1, {($bits(field_t) - 1){1'b0}}};

	// Address map, word addresses
	localparam lb_addr_t addr_drive = 17'd0;
	localparam lb_addr_t addr_coupling_base = 17'd1;
	localparam lb_addr_t addr_shift_base = 17'd4;
	localparam lb_addr_t addr_step = 17'd7;
	localparam lb_addr_t addr_clear = 17'd8;
	localparam lb_addr_t addr_state_base = 17'd16;
	localparam lb_addr_t addr_field = 17'd24;
	localparam lb_addr_t addr_status = 17'd25;

	localparam int lb_read_latency = 2;

	typedef struct packed {
		logic step_en;
		logic clear;
	} core_ctl_t;

	typedef struct packed {
		coupling_t coupling;
		shift_t shift;
	} mode_cfg_t;

endpackage

/* cryomodule.sv */
`timescale 1ns/1ps

module cryomodule import cmoc_pkg::*; (
	input  logic     clk1x,
	input  logic     reset,
	input  lb_addr_t lb_addr,
	input  lb_data_t lb_data,
	input  logic     lb_write,
	input  logic     lb_read,
	output lb_data_t lb_out,
	output logic     lb_rd_valid
);

	drive_t drive;
	mode_cfg_t cfg [mode_count];
	core_ctl_t ctl;
	drive_t mode_in [mode_count];
	mode_state_t states [mode_count];
	field_t field;

	// Host access, configuration and step sequencing
	lb_control i_lb_control (
		.clk1x       (clk1x),
		.reset       (reset),
		.lb_addr     (lb_addr),
		.lb_data     (lb_data),
		.lb_write    (lb_write),
		.lb_read     (lb_read),
		.lb_out      (lb_out),
		.lb_rd_valid (lb_rd_valid),
		.drive       (drive),
		.cfg         (cfg),
		.ctl         (ctl),
		.states      (states),
		.field       (field)
	);

	// Common drive split into per-mode coupled drive
	mode_drive i_mode_drive (
		.clk1x   (clk1x),
		.reset   (reset),
		.drive   (drive),
		.cfg     (cfg),
		.mode_in (mode_in)
	);

	for (genvar k = 0; k < mode_count; k++) begin : g_mode
		resonator_mode i_mode (
			.clk1x (clk1x),
			.reset (reset),
			.drive (mode_in[k]),
			.shift (cfg[k].shift),
			.ctl   (ctl),
			.state (states[k])
		);
	end

	// All modes summed into the cavity field
	field_sum i_field_sum (
		.clk1x  (clk1x),
		.reset  (reset),
		.states (states),
		.field  (field)
	);

endmodule

/* cryomodule_assertions.sv */
`timescale 1ns/1ps

module cryomodule_assertions import cmoc_pkg::*; (
	input logic        clk1x,
	input logic        reset,
	input logic        lb_write,
	input logic        lb_read,
	input logic        lb_rd_valid,
	input core_ctl_t   ctl,
	input step_count_t step_count
);

	int error_count = 0;

	// Every read returns data after the fixed latency
	a_read_latency: assert property (@(posedge clk1x) disable iff (reset)
		lb_read |-> ##lb_read_latency lb_rd_valid)
	else begin
		error_count++;
		$error("lb_rd_valid missing after a read");
	end

	// No valid without a read two cycles before
	a_valid_source: assert property (@(posedge clk1x) disable iff (reset)
		lb_rd_valid |-> $past(lb_read, lb_read_latency))
	else begin
		error_count++;
		$error("lb_rd_valid without a matching read");
	end

	a_clear_pulse: assert property (@(posedge clk1x) disable iff (reset)
		ctl.clear |=> !ctl.clear)
	else begin
		error_count++;
		$error("clear held high for two cycles");
	end

	// Steps stop once the last one has run
	a_step_count: assert property (@(posedge clk1x) disable iff (reset)
		ctl.step_en && step_count == step_count_t'(1) && !lb_write |=> !ctl.step_en)
	else begin
		error_count++;
		$error("step_en high with no steps remaining");
	end

endmodule

/* cryomodule_tb.sv */
`timescale 1ns/1ps

module cryomodule_tb import cmoc_pkg::*; ();

	localparam int read_timeout = 20;
	localparam int step_poll_limit = 400;

	logic clk1x;
	logic reset;
	lb_addr_t lb_addr;
	lb_data_t lb_data;
	logic lb_write;
	logic lb_read;
	lb_data_t lb_out;
	logic lb_rd_valid;

	// Reference model of the configuration and mode states
	drive_t m_drive;
	coupling_t m_coupling [mode_count];
	shift_t m_shift [mode_count];
	mode_state_t m_state [mode_count];

	logic [31:0] lcg_state;
	lb_addr_t read_addrs [$];
	lb_data_t read_data [$];

	tb_clock i_clock (
		.clk1x (clk1x),
		.reset (reset)
	);

	cryomodule i_dut (
		.clk1x       (clk1x),
		.reset       (reset),
		.lb_addr     (lb_addr),
		.lb_data     (lb_data),
		.lb_write    (lb_write),
		.lb_read     (lb_read),
		.lb_out      (lb_out),
		.lb_rd_valid (lb_rd_valid)
	);

	bind lb_control cryomodule_assertions i_assertions (
		.clk1x       (clk1x),
		.reset       (reset),
		.lb_write    (lb_write),
		.lb_read     (lb_read),
		.lb_rd_valid (lb_rd_valid),
		.ctl         (ctl),
		.step_count  (step_count)
	);

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic int random_below(input int n);
		logic [31:0] r;
		r = next_random();
		// Low LCG bits repeat quickly, so use the upper ones
		return int'((r >> 8) % n);
	endfunction

	// Coupled drive scaled by 16 fraction bits and held in the drive range
	function automatic drive_t coupled_drive(input int k);
		longint product;
		longint scaled;
		product = longint'(m_drive) * longint'(m_coupling[k]);
		scaled = product >>> 16;
		if (scaled > longint'(drive_max))
			scaled = longint'(drive_max);
		if (scaled < longint'(drive_min))
			scaled = longint'(drive_min);
		return drive_t'(scaled);
	endfunction

	function automatic void model_step();
		int diff;
		for (int k = 0; k < mode_count; k++) begin
			diff = int'(coupled_drive(k)) - int'(m_state[k]);
			m_state[k] = mode_state_t'(int'(m_state[k]) + (diff >>> m_shift[k]));
		end
	endfunction

	function automatic field_t model_field();
		longint sum;
		sum = 0;
		for (int k = 0; k < mode_count; k++)
			sum += longint'(m_state[k]);
		if (sum > longint'(field_max))
			sum = longint'(field_max);
		if (sum < longint'(field_min))
			sum = longint'(field_min);
		return field_t'(sum);
	endfunction

	// Read value per address with no steps pending
	function automatic lb_data_t expected_read(input lb_addr_t a);
		if (a == addr_drive)
			return lb_data_t'(m_drive);
		if (a == addr_field)
			return lb_data_t'(model_field());
		for (int k = 0; k < mode_count; k++) begin
			if (a == lb_addr_t'(addr_coupling_base + k))
				return lb_data_t'(m_coupling[k]);
			if (a == lb_addr_t'(addr_shift_base + k))
				return lb_data_t'(m_shift[k]);
			if (a == lb_addr_t'(addr_state_base + k))
				return lb_data_t'(m_state[k]);
		end
		return '0;
	endfunction

	task automatic stop_run();
		$display("TESTBENCH FAILED");
		$fatal(1, "Simulation stopped after the first error");
	endtask

	task automatic fail_plain(input string what);
		$display("Error: %s", what);
		stop_run();
	endtask

	task automatic check_state(input string name, input mode_state_t expected,
			input mode_state_t actual);
		if (actual !== expected) begin
			$display("Fail %s: expected %0d, actual %0d", name, expected, actual);
			stop_run();
		end
	endtask

	task automatic check_field(input string name, input field_t expected, input field_t actual);
		if (actual !== expected) begin
			$display("Fail %s: expected %0d, actual %0d", name, expected, actual);
			stop_run();
		end
	endtask

	task automatic check_status(input string name, input step_count_t expected,
			input step_count_t actual);
		if (actual !== expected) begin
			$display("Fail %s: expected %0d, actual %0d", name, expected, actual);
			stop_run();
		end
	endtask

	task automatic check_word(input string name, input lb_data_t expected, input lb_data_t actual);
		if (actual !== expected) begin
			$display("Fail %s: expected %h, actual %h", name, expected, actual);
			stop_run();
		end
	endtask

	// Bus tasks start and end on a falling edge with the bus idle
	task automatic bus_write(input lb_addr_t addr, input lb_data_t data);
		lb_addr = addr;
		lb_data = data;
		lb_write = 1'b1;
		@(negedge clk1x);
		lb_write = 1'b0;
	endtask

	// Issues every queued read back to back and collects the results in order
	task automatic read_burst();
		int issued;
		int cycles;
		issued = 0;
		cycles = 0;
		read_data = {};
		while (read_data.size() < read_addrs.size()) begin
			if (issued < read_addrs.size()) begin
				lb_addr = read_addrs[issued];
				lb_read = 1'b1;
				issued++;
			end else begin
				lb_read = 1'b0;
			end
			@(negedge clk1x);
			if (lb_rd_valid)
				read_data.push_back(lb_out);
			cycles++;
			if (cycles > read_addrs.size() + read_timeout)
				fail_plain("lb_rd_valid did not arrive for a read");
		end
		lb_read = 1'b0;
	endtask

	task automatic bus_read(input lb_addr_t addr, output lb_data_t data);
		read_addrs = {addr};
		read_burst();
		data = read_data[0];
	endtask

	task automatic set_drive(input drive_t d);
		bus_write(addr_drive, lb_data_t'(d));
		m_drive = d;
	endtask

	task automatic set_mode(input int k, input coupling_t c, input shift_t s);
		bus_write(lb_addr_t'(addr_coupling_base + k), lb_data_t'(c));
		bus_write(lb_addr_t'(addr_shift_base + k), lb_data_t'(s));
		m_coupling[k] = c;
		m_shift[k] = s;
	endtask

	task automatic configure_random();
		set_drive(drive_t'(next_random() >> 14));
		for (int k = 0; k < mode_count; k++)
			set_mode(k, coupling_t'(next_random() >> 15), shift_t'(1 + random_below(15)));
	endtask

	// Polls the status until the count reaches zero
	task automatic wait_steps_done(input step_count_t n);
		lb_data_t data;
		step_count_t last;
		int polls;
		last = n;
		polls = 0;
		do begin
			bus_read(addr_status, data);
			if (step_count_t'(data) > last)
				fail_plain("status count went up during a step run");
			last = step_count_t'(data);
			polls++;
			if (polls > step_poll_limit && last != '0)
				fail_plain("step run did not finish in time");
		end while (last != '0);
	endtask

	task automatic run_steps(input step_count_t n);
		bus_write(addr_step, lb_data_t'(n));
		for (int i = 0; i < n; i++)
			model_step();
		wait_steps_done(n);
	endtask

	task automatic check_all_modes(input string name);
		lb_data_t data;
		for (int k = 0; k < mode_count; k++) begin
			bus_read(lb_addr_t'(addr_state_base + k), data);
			if (data !== lb_data_t'(mode_state_t'(data)))
				fail_plain("state read is not sign-extended");
			check_state($sformatf("%s state %0d", name, k), m_state[k], mode_state_t'(data));
		end
		bus_read(addr_field, data);
		if (data !== lb_data_t'(field_t'(data)))
			fail_plain("field read is not sign-extended");
		check_field($sformatf("%s field", name), model_field(), field_t'(data));
	endtask

	task automatic wait_reset_release();
		int cycles;
		cycles = 0;
		@(negedge clk1x);
		while (reset) begin
			@(negedge clk1x);
			cycles++;
			if (cycles > read_timeout)
				fail_plain("reset was never released");
		end
	endtask

	always @(negedge clk1x) begin
		if (i_dut.i_lb_control.i_assertions.error_count != 0)
			fail_plain("a bus or step protocol assertion failed");
	end

	initial begin
		lb_data_t data;
		lcg_state = 32'h6899_4432;
		lb_addr = '0;
		lb_data = '0;
		lb_write = 1'b0;
		lb_read = 1'b0;
		m_drive = '0;
		for (int k = 0; k < mode_count; k++) begin
			m_coupling[k] = '0;
			m_shift[k] = shift_t'(1);
			m_state[k] = '0;
		end
		wait_reset_release();

		check_all_modes("reset");
		bus_read(addr_status, data);
		check_status("reset status", '0, step_count_t'(data));

		configure_random();
		run_steps(step_count_t'(1 + random_below(60)));
		check_all_modes("single run");

		// Different shifts settle at different rates
		set_mode(0, coupling_t'(next_random() >> 15), shift_t'(1));
		set_mode(1, coupling_t'(next_random() >> 15), shift_t'(4));
		set_mode(2, coupling_t'(next_random() >> 15), shift_t'(9));
		for (int i = 0; i < 5; i++) begin
			if (i == 2)
				set_drive(drive_t'(next_random() >> 14));
			run_steps(step_count_t'(1 + random_below(40)));
			check_all_modes($sformatf("accumulate %0d", i));
		end

		// Largest mode sum in both directions
		set_drive(drive_max);
		for (int k = 0; k < mode_count; k++)
			set_mode(k, '1, shift_t'(1));
		run_steps(step_count_t'(80));
		check_all_modes("full scale positive");
		set_drive(drive_min);
		run_steps(step_count_t'(80));
		check_all_modes("full scale negative");

		// Clear in the middle of a long run
		configure_random();
		bus_write(addr_step, lb_data_t'(500));
		bus_read(addr_status, data);
		if (step_count_t'(data) == '0 || step_count_t'(data) >= step_count_t'(500))
			fail_plain("step count did not count down during a run");
		bus_write(addr_clear, '0);
		for (int k = 0; k < mode_count; k++)
			m_state[k] = '0;
		bus_read(addr_status, data);
		check_status("status after clear", '0, step_count_t'(data));
		check_all_modes("after clear");
		run_steps(step_count_t'(1 + random_below(50)));
		check_all_modes("restart after clear");

		// All addresses back to back plus one far outside the map
		read_addrs = {};
		for (int a = 0; a <= 26; a++)
			read_addrs.push_back(lb_addr_t'(a));
		read_addrs.push_back(17'h1_0010);
		read_burst();
		for (int i = 0; i < read_addrs.size(); i++)
			check_word($sformatf("burst read at %0d", read_addrs[i]),
				expected_read(read_addrs[i]), read_data[i]);

		@(negedge clk1x);
		if (i_dut.i_lb_control.i_assertions.error_count == 0) begin
			$display("TESTBENCH PASSED");
			$finish;
		end else begin
			fail_plain("a bus or step protocol assertion failed");
		end
	end

endmodule

/* field_sum.sv */
`timescale 1ns/1ps

module field_sum import cmoc_pkg::*; (
	input  logic        clk1x,
	input  logic        reset,
	input  mode_state_t states [mode_count],
	output field_t      field
);

	// Wide enough that the sum of all modes cannot overflow
	logic signed [$bits(mode_state_t)+$clog2(mode_count):0] total;
	field_t clamped;

	always_comb begin
		total = '0;
		for (int k = 0; k < mode_count; k++)
			total = total + states[k];
	end

	// Saturate to the field range
	always_comb begin
		if (total > field_max)
			clamped = field_max;
		else if (total < field_min)
			clamped = field_min;
		else
			clamped = field_t'(total);
	end

	always_ff @(posedge clk1x) begin
		if (reset)
			field <= '0;
		else
			field <= clamped;
	end

endmodule

/* lb_control.sv */
`timescale 1ns/1ps

module lb_control import cmoc_pkg::*; (
	input  logic        clk1x,
	input  logic        reset,
	input  lb_addr_t    lb_addr,
	input  lb_data_t    lb_data,
	input  logic        lb_write,
	input  logic        lb_read,
	output lb_data_t    lb_out,
	output logic        lb_rd_valid,
	output drive_t      drive,
	output mode_cfg_t   cfg [mode_count],
	output core_ctl_t   ctl,
	input  mode_state_t states [mode_count],
	input  field_t      field
);

	step_count_t step_count;
	logic clear_q;
	logic [lb_read_latency-1:0] rd_pipe;
	lb_addr_t rd_addr_q;
	lb_data_t rd_data;

	// Steps run while the count is nonzero
	assign ctl = '{step_en: (step_count != '0), clear: clear_q};

	// Configuration registers, step counter and clear pulse
	always_ff @(posedge clk1x) begin
		if (reset) begin
			drive <= '0;
			for (int k = 0; k < mode_count; k++) begin
				cfg[k].coupling <= '0;
				cfg[k].shift <= shift_t'(1);
			end
			step_count <= '0;
			clear_q <= 1'b0;
		end else begin
			clear_q <= lb_write && (lb_addr == addr_clear);
			if (ctl.step_en)
				step_count <= step_count - 1'b1;
			if (lb_write) begin
				if (lb_addr == addr_drive)
					drive <= drive_t'(lb_data);
				for (int k = 0; k < mode_count; k++) begin
					if (lb_addr == lb_addr_t'(addr_coupling_base + k))
						cfg[k].coupling <= coupling_t'(lb_data);
					if (lb_addr == lb_addr_t'(addr_shift_base + k))
						cfg[k].shift <= shift_t'(lb_data);
				end
				// A zero count is ignored, a nonzero one replaces what is left
				if (lb_addr == addr_step && step_count_t'(lb_data) != '0)
					step_count <= step_count_t'(lb_data);
				// Clear also cancels the remaining steps
				if (lb_addr == addr_clear)
					step_count <= '0;
			end
		end
	end

	// First read stage: capture address, track valid through the pipe
	always_ff @(posedge clk1x) begin
		if (reset)
			rd_pipe <= '0;
		else
			rd_pipe <= {rd_pipe[lb_read_latency-2:0], lb_read};
	end

	always_ff @(posedge clk1x) begin
		rd_addr_q <= lb_addr;
	end

	// Read mux on the registered address, unmapped reads give zero
	always_comb begin
		rd_data = '0;
		if (rd_addr_q == addr_drive)
			rd_data = lb_data_t'(drive);
		if (rd_addr_q == addr_field)
			rd_data = lb_data_t'(field);
		if (rd_addr_q == addr_status)
			rd_data = lb_data_t'(step_count);
		for (int k = 0; k < mode_count; k++) begin
			if (rd_addr_q == lb_addr_t'(addr_coupling_base + k))
				rd_data = lb_data_t'(cfg[k].coupling);
			if (rd_addr_q == lb_addr_t'(addr_shift_base + k))
				rd_data = lb_data_t'(cfg[k].shift);
			if (rd_addr_q == lb_addr_t'(addr_state_base + k))
				rd_data = lb_data_t'(states[k]);
		end
	end

	// Second read stage: register the selected data
	always_ff @(posedge clk1x) begin
		lb_out <= rd_data;
	end

	assign lb_rd_valid = rd_pipe[lb_read_latency-1];

endmodule

/* mode_drive.sv */
`timescale 1ns/1ps

module mode_drive import cmoc_pkg::*; (
	input  logic      clk1x,
	input  logic      reset,
	input  drive_t    drive,
	input  mode_cfg_t cfg [mode_count],
	output drive_t    mode_in [mode_count]
);

	// Full-width signed product of drive and coupling
	logic signed [$bits(drive_t)+$bits(coupling_t):0] product [mode_count];
	logic signed [$bits(drive_t)+$bits(coupling_t):0] scaled [mode_count];
	drive_t limited [mode_count];

	always_comb begin
		for (int k = 0; k < mode_count; k++) begin
			// Coupling is unsigned, so extend it with a zero sign bit
			product[k] = drive * $signed({1'b0, cfg[k].coupling});
			scaled[k] = product[k] >>> coupling_frac;
			// Couplings above 1.0 can push past the drive range
			if (scaled[k] > drive_max)
				limited[k] = drive_max;
			else if (scaled[k] < drive_min)
				limited[k] = drive_min;
			else
				limited[k] = drive_t'(scaled[k]);
		end
	end

	// Register every mode's drive so all modes see one cycle of latency
	always_ff @(posedge clk1x) begin
		if (reset) begin
			for (int k = 0; k < mode_count; k++)
				mode_in[k] <= '0;
		end else begin
			for (int k = 0; k < mode_count; k++)
				mode_in[k] <= limited[k];
		end
	end

endmodule

/* resonator_mode.sv */
`timescale 1ns/1ps

module resonator_mode import cmoc_pkg::*; (
	input  logic        clk1x,
	input  logic        reset,
	input  drive_t      drive,
	input  shift_t      shift,
	input  core_ctl_t   ctl,
	output mode_state_t state
);

	// One extra bit so the difference never wraps
	logic signed [$bits(mode_state_t):0] diff;
	logic signed [$bits(mode_state_t):0] delta;
	mode_state_t state_next;

	// Leaky integrator, state moves a fraction of the way to the drive
	always_comb begin
		diff = drive - state;
		// Larger shift means narrower bandwidth and slower settling
		delta = diff >>> shift;
		// Result lies between old state and drive, so it fits
		state_next = mode_state_t'(state + delta);
	end

	// Clear wins over a step in the same cycle
	always_ff @(posedge clk1x) begin
		if (reset)
			state <= '0;
		else if (ctl.clear)
			state <= '0;
		else if (ctl.step_en)
			state <= state_next;
	end

endmodule

/* tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
	output logic clk1x,
	output logic reset
);

	// 10 ns period
	initial begin
		clk1x = 1'b0;
		forever #5 clk1x = ~clk1x;
	end

	// Reset held high for five rising edges
	initial begin
		reset = 1'b1;
		repeat (5) @(posedge clk1x);
		reset <= 1'b0;
	end

endmodule

/* verilog.f */
cmoc_pkg.sv
lb_control.sv
mode_drive.sv
resonator_mode.sv
field_sum.sv
cryomodule.sv
tb_clock.sv
cryomodule_assertions.sv
cryomodule_tb.sv
